// File: rtl/cps2_dec_pkg.sv
package cps2_dec_pkg;

    // ******************************************************************
    // widths
    // ******************************************************************
    localparam int WORD_W = 16;  // data word and per-word key
    localparam int HALF_W = 8;   // feistel half
    localparam int MKEY_W = 64;  // master key
    localparam int RKEY_W = 24;  // one round key, four 6-bit box keys

    // one s-box: 64 entries of 2 bits, entry v sits at bits [2v+1:2v]
    typedef logic [127:0] SBOX_T;

    // ******************************************************************
    // substitution boxes, index is round*4 + box
    // ******************************************************************
    localparam SBOX_T [0:15] SBOX_TAB = {
        128'h4e1b_d278_9ac3_605f_b817_e42d_3c96_a05b,  // round 1
        128'h93d6_0a7e_c15b_28f4_6e09_b3a7_d452_1fc8,
        128'h2bf0_8e63_d91a_47c5_a36e_0d8b_f517_92c4,
        128'hd75a_1c8e_3b46_f029_84e3_6db1_2a9f_c570,
        128'h68c1_f34b_a92e_075d_1db8_e6a0_4c73_9f25,  // round 2
        128'hb04f_7e29_52d8_c1a6_f93b_084e_d765_3a1c,
        128'h1e97_a4c2_6b5d_f803_c72a_5e94_0bf1_86d3,
        128'hf62c_3d81_e0a5_7b94_29d6_c18f_a34e_570b,
        128'h857e_b21c_4f0a_d396_e48b_72c5_19a0_6dfe,  // round 3
        128'h3ca9_6f04_8bd2_e15b_7046_1fc9_b8e3_d2a7,
        128'hc24d_953b_07fe_6a18_d59c_a20b_e674_3f81,
        128'h7b13_e8d6_5c20_9fa4_8ad1_36e7_c05b_f492,
        128'ha6f8_21c7_d34e_0b95_5f2a_e8c3_9716_4db0,  // round 4
        128'h0d52_bc9a_61f7_e348_b69e_4d05_a2c8_17f3,
        128'he931_4a6b_f8c5_d207_3b7f_915e_06ad_c84a,
        128'h5f8e_073d_b4a9_c16e_92c0_fb38_6d17_a5e4
    };

    // half-word bits feeding each box, element k lands on box input bit k
    localparam int SBOX_SEL [16][6] = '{
        '{0, 2, 3, 5, 6, 7}, '{1, 2, 4, 5, 6, 7}, '{0, 1, 3, 4, 6, 7}, '{0, 1, 2, 3, 4, 5},
        '{1, 3, 4, 5, 6, 7}, '{0, 2, 3, 4, 5, 6}, '{0, 1, 2, 5, 6, 7}, '{0, 1, 3, 4, 5, 7},
        '{0, 1, 2, 4, 6, 7}, '{1, 2, 3, 5, 6, 7}, '{0, 2, 3, 4, 5, 7}, '{0, 1, 3, 4, 5, 6},
        '{2, 3, 4, 5, 6, 7}, '{0, 1, 2, 3, 6, 7}, '{0, 1, 4, 5, 6, 7}, '{0, 2, 3, 4, 6, 7}
    };

    // ******************************************************************
    // key schedule tables
    // ******************************************************************

    // pre-key bit i = word_key[KEY_PERM[i]], each word-key bit used 4 times
    localparam int KEY_PERM [64] = '{
         3, 12,  7,  0,  9, 14,  5, 10,  1, 15,  6, 11,  2,  8, 13,  4,
        11,  2, 15,  6, 13,  4,  8,  1, 14,  0, 10,  5, 12,  7,  3,  9,
         6,  9,  0, 13,  3, 10, 15,  2,  7, 12,  4, 14,  1, 11,  5,  8,
        14,  5, 10,  8,  1, 11,  3, 12,  0,  6, 13,  9, 15,  4,  2,  7
    };

    // round-key bit i = kext[RKEY_PICK[i]]
    // first 64 cover every extended bit once, the rest repeat some
    localparam int RKEY_PICK [96] = '{
        11, 48, 21, 58, 31,  4, 41, 14, 51, 24, 61, 34,  7, 44, 17, 54,
        27,  0, 37, 10, 47, 20, 57, 30,  3, 40, 13, 50, 23, 60, 33,  6,
        43, 16, 53, 26, 63, 36,  9, 46, 19, 56, 29,  2, 39, 12, 49, 22,
        59, 32,  5, 42, 15, 52, 25, 62, 35,  8, 45, 18, 55, 28,  1, 38,
         5, 28, 51, 10, 33, 56, 15, 38, 61, 20, 43,  2, 25, 48,  7, 30,
        53, 12, 35, 58, 17, 40, 63, 22, 45,  4, 27, 50,  9, 32, 55, 14
    };

    // {dst, src} after the pick: bit dst ^= bit src
    // no src is ever a dst so the order does not matter
    localparam int RKEY_FOLD [8][2] = '{
        '{ 5,  1}, '{10,  7},  // round 1
        '{29, 24}, '{27, 26},  // round 2
        '{52, 49}, '{47, 44},  // rounds 3 and 2
        '{70, 64}, '{94, 90}   // rounds 3 and 4
    };

    // ******************************************************************
    // word <-> halves scatter
    // ******************************************************************

    // {left, right} bit i = din[IN_PERM[i]], right half is bits 7..0
    localparam int IN_PERM [16] = '{
         9,  2, 14,  5, 11,  0,  7, 12,
         4, 15,  1, 10,  6, 13,  3,  8
    };

    // inverse of IN_PERM: dout[j] = {left, right}[OUT_PERM[j]]
    localparam int OUT_PERM [16] = '{
         5, 10,  1, 14,  8,  3, 12,  6,
        15,  0, 11,  4,  7, 13,  2,  9
    };

endpackage

// File: rtl/cps2_fn2_keysched.sv
module cps2_fn2_keysched (
    input  logic [cps2_dec_pkg::WORD_W-1:0] word_key,
    input  logic [cps2_dec_pkg::MKEY_W-1:0] master_key,
    output logic [cps2_dec_pkg::RKEY_W-1:0] rkey1,
    output logic [cps2_dec_pkg::RKEY_W-1:0] rkey2,
    output logic [cps2_dec_pkg::RKEY_W-1:0] rkey3,
    output logic [cps2_dec_pkg::RKEY_W-1:0] rkey4
);

    logic [cps2_dec_pkg::MKEY_W-1:0]   kpre;       // word key spread over 64 bits
    logic [cps2_dec_pkg::MKEY_W-1:0]   kext;       // pre-key mixed with master key
    logic [4*cps2_dec_pkg::RKEY_W-1:0] full_keys;  // all four round keys

    // ******************************************************************
    // expansion of the word key
    // ******************************************************************
    always_comb begin
        for (int i = 0; i < cps2_dec_pkg::MKEY_W; i++) begin
            kpre[i] = word_key[cps2_dec_pkg::KEY_PERM[i]];
        end
    end

    assign kext = kpre ^ master_key;

    // ******************************************************************
    // pick and fold
    // ******************************************************************
    always_comb begin
        for (int i = 0; i < 4 * cps2_dec_pkg::RKEY_W; i++) begin
            full_keys[i] = kext[cps2_dec_pkg::RKEY_PICK[i]];
        end
        // folds only touch bits of their own round key
        for (int f = 0; f < 8; f++) begin
            full_keys[cps2_dec_pkg::RKEY_FOLD[f][0]] =
                full_keys[cps2_dec_pkg::RKEY_FOLD[f][0]] ^
                full_keys[cps2_dec_pkg::RKEY_FOLD[f][1]];
        end
    end

    // round one takes the lowest 24 bits
    assign rkey1 = full_keys[0*cps2_dec_pkg::RKEY_W +: cps2_dec_pkg::RKEY_W];
    assign rkey2 = full_keys[1*cps2_dec_pkg::RKEY_W +: cps2_dec_pkg::RKEY_W];
    assign rkey3 = full_keys[2*cps2_dec_pkg::RKEY_W +: cps2_dec_pkg::RKEY_W];
    assign rkey4 = full_keys[3*cps2_dec_pkg::RKEY_W +: cps2_dec_pkg::RKEY_W];

endmodule

// File: rtl/cps2_fn2_round.sv
module cps2_fn2_round #(
    parameter int ROUND = 0  // 0..3, picks the four boxes of this round
) (
    input  logic [cps2_dec_pkg::HALF_W-1:0] half,
    input  logic [cps2_dec_pkg::RKEY_W-1:0] rkey,
    output logic [cps2_dec_pkg::HALF_W-1:0] fout
);

    localparam int BASE = ROUND * 4;  // first table entry of this round

    // ******************************************************************
    // four 6-in 2-out boxes
    // ******************************************************************
    for (genvar b = 0; b < 4; b++) begin : g_box
        logic [5:0] sel_bits;  // gathered half-word bits
        logic [5:0] sbox_in;   // after the key slice

        always_comb begin
            for (int k = 0; k < 6; k++) begin
                sel_bits[k] = half[cps2_dec_pkg::SBOX_SEL[BASE+b][k]];
            end
        end

        assign sbox_in = sel_bits ^ rkey[6*b +: 6];

        // box b drives output bits 2b+1..2b
        assign fout[2*b +: 2] = cps2_dec_pkg::SBOX_TAB[BASE+b][{sbox_in, 1'b0} +: 2];
    end

endmodule

// File: rtl/cps2_fn2_feistel.sv
module cps2_fn2_feistel #(
    parameter int PIPE_MID = 1  // 1: register between rounds two and three
) (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            in_valid,
    input  logic [cps2_dec_pkg::WORD_W-1:0] din,
    input  logic [cps2_dec_pkg::WORD_W-1:0] word_key,
    input  logic [cps2_dec_pkg::MKEY_W-1:0] master_key,
    output logic                            out_valid,
    output logic [cps2_dec_pkg::WORD_W-1:0] dout
);

    logic [cps2_dec_pkg::RKEY_W-1:0] rkey1, rkey2, rkey3, rkey4;
    logic [cps2_dec_pkg::RKEY_W-1:0] rkey3_s, rkey4_s;  // second-half keys
    logic [cps2_dec_pkg::HALF_W-1:0] l0, r0, r1, r2, r3, r4;
    logic [cps2_dec_pkg::HALF_W-1:0] f1, f2, f3, f4;
    logic [cps2_dec_pkg::HALF_W-1:0] l2_s, r2_s;        // halves entering round three
    logic                            valid_s;
    logic [cps2_dec_pkg::WORD_W-1:0] lr_in, pre_out, dout_d;

    // ******************************************************************
    // first half: key schedule, rounds one and two
    // ******************************************************************
    always_comb begin
        for (int i = 0; i < cps2_dec_pkg::WORD_W; i++) begin
            lr_in[i] = din[cps2_dec_pkg::IN_PERM[i]];
        end
    end
    assign {l0, r0} = lr_in;

    cps2_fn2_keysched u_keys (
        .word_key  (word_key),   .master_key (master_key),
        .rkey1     (rkey1),      .rkey2      (rkey2),
        .rkey3     (rkey3),      .rkey4      (rkey4)
    );

    cps2_fn2_round #(.ROUND(0)) u_r1 (.half(r0), .rkey(rkey1), .fout(f1));
    cps2_fn2_round #(.ROUND(1)) u_r2 (.half(r1), .rkey(rkey2), .fout(f2));

    assign r1 = f1 ^ l0;
    assign r2 = f2 ^ r0;  // left of round two is r0

    if (PIPE_MID != 0) begin : g_mid
        always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
                valid_s <= 1'b0;
            end else begin
                valid_s <= in_valid;
            end
        end
        always_ff @(posedge clk) begin
            l2_s    <= r1;
            r2_s    <= r2;
            rkey3_s <= rkey3;
            rkey4_s <= rkey4;
        end
    end else begin : g_flat
        assign valid_s = in_valid;
        assign {l2_s, r2_s} = {r1, r2};
        assign {rkey3_s, rkey4_s} = {rkey3, rkey4};
    end

    // ******************************************************************
    // second half: rounds three and four, output register
    // ******************************************************************
    cps2_fn2_round #(.ROUND(2)) u_r3 (.half(r2_s), .rkey(rkey3_s), .fout(f3));
    cps2_fn2_round #(.ROUND(3)) u_r4 (.half(r3),   .rkey(rkey4_s), .fout(f4));

    assign r3 = f3 ^ l2_s;
    assign r4 = f4 ^ r2_s;
    assign pre_out = {r3, r4};  // last left half is r3

    always_comb begin
        for (int j = 0; j < cps2_dec_pkg::WORD_W; j++) begin
            dout_d[j] = pre_out[cps2_dec_pkg::OUT_PERM[j]];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= valid_s;
        end
    end

    always_ff @(posedge clk) begin
        if (valid_s) dout <= dout_d;  // hold last word between strobes
    end

    // data behind every strobe has passed the whole network
    a_dout_known : assert property (@(posedge clk) disable iff (!arst_n)
        out_valid |-> !$isunknown(dout));

endmodule

// File: rtl/cps2_dec_top.sv
module cps2_dec_top #(
    parameter int PIPE_MID = 1  // adds one cycle of latency when set
) (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            in_valid,
    input  logic [cps2_dec_pkg::WORD_W-1:0] din,
    input  logic [cps2_dec_pkg::WORD_W-1:0] word_key,
    input  logic                            key_wr,
    input  logic [1:0]                      key_sel,
    input  logic [cps2_dec_pkg::WORD_W-1:0] key_data,
    output logic                            out_valid,
    output logic [cps2_dec_pkg::WORD_W-1:0] dout
);

    logic [cps2_dec_pkg::MKEY_W-1:0] master_key;
    logic                            in_valid_q;
    logic [cps2_dec_pkg::WORD_W-1:0] din_q;
    logic [cps2_dec_pkg::WORD_W-1:0] word_key_q;

    // ******************************************************************
    // master key, written one 16-bit slice at a time
    // ******************************************************************
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            master_key <= '0;
        end else if (key_wr) begin
            // slice 0 is bits 15..0
            master_key[key_sel*cps2_dec_pkg::WORD_W +: cps2_dec_pkg::WORD_W] <= key_data;
        end
    end

    // ******************************************************************
    // input register
    // ******************************************************************
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            in_valid_q <= 1'b0;
        end else begin
            in_valid_q <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            din_q      <= din;
            word_key_q <= word_key;
        end
    end

    cps2_fn2_feistel #(
        .PIPE_MID (PIPE_MID)
    ) u_core (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_valid   (in_valid_q),
        .din        (din_q),
        .word_key   (word_key_q),
        .master_key (master_key),
        .out_valid  (out_valid),
        .dout       (dout)
    );

    // words in flight: one in the input register, one in the core's mid stage
    a_key_quiet : assert property (@(posedge clk) disable iff (!arst_n)
        key_wr |-> !in_valid_q && !(PIPE_MID != 0 && $past(in_valid_q)));

    a_valid_known : assert property (@(posedge clk) disable iff (!arst_n)
        !$isunknown(out_valid));

endmodule

// File: dv/cps2_dec_ref.svh
`ifndef CPS2_DEC_REF_SVH
`define CPS2_DEC_REF_SVH

// ********************************************************************
// reference model, built straight from the package tables
// ********************************************************************

// all four round keys, round one in bits 23..0
function automatic logic [95:0] round_keys(
    input logic [cps2_dec_pkg::WORD_W-1:0] wkey,
    input logic [cps2_dec_pkg::MKEY_W-1:0] mkey
);
    logic [63:0] ext;
    logic [95:0] rk;
    logic        src;
    ext = '0;
    rk  = '0;
    for (int i = 0; i < 64; i++) begin
        ext = ext | (64'(1'(wkey >> cps2_dec_pkg::KEY_PERM[6'(i)])) << i);
    end
    ext = ext ^ mkey;
    for (int i = 0; i < 96; i++) begin
        rk = rk | (96'(1'(ext >> cps2_dec_pkg::RKEY_PICK[7'(i)])) << i);
    end
    for (int f = 0; f < 8; f++) begin
        src = 1'(rk >> cps2_dec_pkg::RKEY_FOLD[3'(f)][1]);
        rk  = rk ^ (96'(src) << cps2_dec_pkg::RKEY_FOLD[3'(f)][0]);
    end
    return rk;
endfunction

// one round: four boxes of round rnd on a half word
function automatic logic [7:0] round_out(input int rnd, input logic [7:0] half,
                                         input logic [23:0] rkey);
    logic [7:0]          res;
    logic [5:0]          sin;   // box input after the key slice
    logic [3:0]          box;
    cps2_dec_pkg::SBOX_T tab;
    res = '0;
    for (int b = 0; b < 4; b++) begin
        box = 4'(rnd * 4 + b);
        sin = '0;
        for (int k = 0; k < 6; k++) begin
            sin = sin | (6'(1'(half >> cps2_dec_pkg::SBOX_SEL[box][3'(k)])) << k);
        end
        sin = sin ^ 6'(rkey >> (6 * b));
        tab = cps2_dec_pkg::SBOX_TAB[box];
        res = res | (8'(2'(tab >> (2 * sin))) << (2 * b));  // entry v at bits 2v+1..2v
    end
    return res;
endfunction

function automatic logic [15:0] cps2_dec_ref(
    input logic [cps2_dec_pkg::WORD_W-1:0] word,
    input logic [cps2_dec_pkg::WORD_W-1:0] wkey,
    input logic [cps2_dec_pkg::MKEY_W-1:0] mkey
);
    logic [95:0] rk;
    logic [15:0] lr;
    logic [15:0] res;
    logic [7:0]  l, r, t;
    rk = round_keys(wkey, mkey);
    lr = '0;
    for (int i = 0; i < 16; i++) begin
        lr = lr | (16'(1'(word >> cps2_dec_pkg::IN_PERM[4'(i)])) << i);
    end
    l = lr[15:8];
    r = lr[7:0];
    for (int n = 0; n < 4; n++) begin
        t = round_out(n, r, 24'(rk >> (24 * n))) ^ l;
        l = r;  // plain swap after every round
        r = t;
    end
    lr  = {l, r};
    res = '0;
    for (int j = 0; j < 16; j++) begin
        res = res | (16'(1'(lr >> cps2_dec_pkg::OUT_PERM[4'(j)])) << j);
    end
    return res;
endfunction

`endif

// File: dv/cps2_dec_tb.sv
module cps2_dec_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int PIPE_MID   = 1;
    localparam int LATENCY    = 2 + PIPE_MID;  // drive edge to output edge
    // about 1350 cycles of stimulus, the rest is margin
    localparam int MAX_CYCLES = 2000;

    logic        clk = 1'b0;
    logic        arst_n;
    logic        in_valid;
    logic [15:0] din;
    logic [15:0] word_key;
    logic        key_wr;
    logic [1:0]  key_sel;
    logic [15:0] key_data;
    logic        out_valid;
    logic [15:0] dout;

    logic [15:0] exp_q[$];    // expected plaintext, oldest first
    int          issue_q[$];  // edge number on which each word was driven
    logic [63:0] mkey;        // master key as the DUT holds it
    int          cycle = 0;
    int          seed = 97728;
    int          n_sent = 0;
    int          n_checked = 0;
    logic [15:0] exp_word;
    int          exp_cycle;

    `include "cps2_dec_ref.svh"

    cps2_dec_top #(
        .PIPE_MID (PIPE_MID)
    ) UUT (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .din       (din),
        .word_key  (word_key),
        .key_wr    (key_wr),
        .key_sel   (key_sel),
        .key_data  (key_data),
        .out_valid (out_valid),
        .dout      (dout)
    );

    always #4 clk = ~clk;  // 8 ns period

    // ******************************************************************
    // helpers
    // ******************************************************************
    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("[ERROR] %0t %s got %0h expected %0h", $time, what, actual, expected);
            $display("** FAIL **");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic logic [15:0] rand_word();
        return 16'($random(seed));
    endfunction

    task automatic send_word(input logic [15:0] word, input logic [15:0] wkey);
        @(posedge clk);
        in_valid <= 1'b1;
        din      <= word;
        word_key <= wkey;
        exp_q.push_back(cps2_dec_ref(word, wkey, mkey));
        issue_q.push_back(cycle + 1);  // counter has not seen this edge yet
        n_sent++;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            in_valid <= 1'b0;
        end
    endtask

    // one slice per cycle, slice 0 first
    task automatic load_master_key(input logic [63:0] key);
        for (int s = 0; s < 4; s++) begin
            @(posedge clk);
            key_wr   <= 1'b1;
            key_sel  <= 2'(s);
            key_data <= 16'(key >> (16 * s));
        end
        @(posedge clk);
        key_wr <= 1'b0;
        mkey = key;
    endtask

    task automatic wait_drained();
        while (exp_q.size() != 0) @(posedge clk);
    endtask

    // ******************************************************************
    // cycle counter and compare process
    // ******************************************************************
    always @(posedge clk) begin
        if (cycle >= MAX_CYCLES) begin
            $display("** FAIL **");
            $fatal(1, "timeout, the run did not finish within %0d cycles", MAX_CYCLES);
        end else begin
            cycle <= cycle + 1;
        end
    end

    // outputs are looked at on the falling edge where they are settled
    always @(negedge clk) begin
        if (arst_n && out_valid) begin
            if (exp_q.size() == 0) begin
                $display("** FAIL **");
                $fatal(1, "output strobe with no word in flight");
            end else begin
                exp_word  = exp_q.pop_front();
                exp_cycle = issue_q.pop_front();
                check_equal(32'(dout), 32'(exp_word), "decrypted word");
                check_equal(32'(cycle - exp_cycle), 32'(LATENCY), "latency in cycles");
                n_checked++;
            end
        end
    end

    // ******************************************************************
    // stimulus
    // ******************************************************************
    initial begin : stimulus
        logic [63:0] edge_keys [6];
        logic [15:0] edge_wkeys [6];
        logic [63:0] new_key;
        int          gap;
        arst_n   = 1'b0;
        in_valid = 1'b0;
        din      = '0;
        word_key = '0;
        key_wr   = 1'b0;
        key_sel  = '0;
        key_data = '0;
        mkey     = '0;
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;

        repeat (10) begin
            @(negedge clk);
            check_equal(32'(out_valid), 32'd0, "out_valid while idle");
        end

        // single words with gaps
        load_master_key(64'h3a5c_96e1_0f72_d4b8);
        for (int i = 0; i < 8; i++) begin
            send_word(rand_word(), rand_word());
            idle_cycles(4);
        end
        wait_drained();

        // back to back stream
        for (int i = 0; i < 500; i++) begin
            send_word(rand_word(), rand_word());
        end
        idle_cycles(1);
        wait_drained();

        // new random key, words with gaps of 0 to 2 cycles
        new_key = {32'($random(seed)), 32'($random(seed))};
        load_master_key(new_key);
        for (int i = 0; i < 300; i++) begin
            send_word(rand_word(), rand_word());
            gap = ($random(seed) & 32'h7fff_ffff) % 3;
            if (gap > 0) idle_cycles(gap);
        end
        idle_cycles(1);
        wait_drained();

        // edge keys
        edge_keys = '{64'h0, {64{1'b1}}, 64'h0000_0000_0000_ffff, 64'h0000_0000_ffff_0000,
                      64'h0000_ffff_0000_0000, 64'hffff_0000_0000_0000};
        edge_wkeys = '{16'h0000, 16'hffff, 16'h000f, 16'h00f0, 16'h0f00, 16'hf000};
        foreach (edge_keys[m]) begin
            load_master_key(edge_keys[m]);
            foreach (edge_wkeys[w]) begin
                send_word(16'h0000, edge_wkeys[w]);
                send_word(16'hffff, edge_wkeys[w]);
                send_word(rand_word(), edge_wkeys[w]);
            end
            idle_cycles(1);
            wait_drained();
        end

        repeat (5) @(posedge clk);  // room for any stray strobe
        if (exp_q.size() != 0 || n_checked != n_sent) begin
            $display("** FAIL **");
            $fatal(1, "only %0d of %0d words came out", n_checked, n_sent);
        end else begin
            $display("checked %0d words", n_checked);
            $display("** PASS **");
            $finish;
        end
    end

endmodule

// File: all.f
+incdir+dv
rtl/cps2_dec_pkg.sv
rtl/cps2_fn2_keysched.sv
rtl/cps2_fn2_round.sv
rtl/cps2_fn2_feistel.sv
rtl/cps2_dec_top.sv
dv/cps2_dec_tb.sv

// File: Makefile
# Verilator build and run of the decryption datapath testbench

VERILATOR ?= verilator
TOP       ?= cps2_dec_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j $(JOBS)

SOURCES := $(filter-out +incdir+%,$(shell cat $(FILELIST)))
HEADERS := dv/cps2_dec_ref.svh
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables"
	@echo "  VERILATOR TOP FILELIST BUILD_DIR JOBS VFLAGS"

# a failing check ends in \$$fatal, so the run step returns non-zero
test: $(SIM)
	./$(SIM)

$(SIM): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
